/* Makefile */
# Verilator build and run of the ALU unit testbench

VERILATOR ?= verilator
TOP       ?= alu_unit_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := tests/alu_unit_tb_ref.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* design/alu_cmd_intake.sv */
`timescale 1ns/1ps

module alu_cmd_intake
  import alu_pkg::*;
#(
  parameter int CMD_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  alu_cmd_t cmd,
  output logic     cmd_credit,
  output logic     head_valid,
  output alu_cmd_t head,
  input  logic     pop
);

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  alu_cmd_t           mem [CMD_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               full;

  assign full       = (count == CNT_W'(CMD_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // storage, no reset needed on payload
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid) begin
        if (wr_ptr == PTR_W'(CMD_DEPTH - 1)) begin
          wr_ptr <= '0;  // wrap
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(CMD_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      count      <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
      cmd_credit <= pop;  // one credit back per freed entry
    end
  end

  // sender spent a credit it never had
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_valid |-> !full
  ) else $error("command arrived with intake FIFO full");

  // execute must only pop a valid head
  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> head_valid
  ) else $error("pop with intake FIFO empty");

endmodule

/* design/alu_exec_stage.sv */
`timescale 1ns/1ps

module alu_exec_stage
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     head_valid,
  input  alu_cmd_t head,
  output logic     pop,
  input  logic     out_ready,
  output logic     issue,
  output alu_res_t issue_res
);

  alu_flags_t flags_q;    // processor flag register
  alu_flags_t alu_flags;
  logic [7:0] alu_value;

  core_alu i_core_alu (
    .ctrl      (head.ctrl),
    .mask_p    (head.mask_p),
    .lhs       (head.lhs),
    .rhs       (head.rhs),
    .flags_in  (flags_q),
    .value     (alu_value),
    .flags_out (alu_flags)
  );

  // issue whenever a command waits and egress has room
  assign issue = head_valid && out_ready;
  assign pop   = issue;

  assign issue_res.value = alu_value;
  assign issue_res.flags = alu_flags;

  // flags chain from one command to the next
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (issue) begin
      flags_q <= alu_flags;
    end
  end

  // a stalled head waits unchanged until it issues
  a_head_held_while_stalled : assert property (
    @(posedge clk) disable iff (!rst_n)
    (head_valid && !out_ready) |=> (head_valid && $stable(head))
  ) else $error("intake head changed or vanished while stalled");

endmodule

/* design/alu_pkg.sv */
package alu_pkg;

  // operation select, encoding follows the decoder's 3-bit field
  typedef enum logic [2:0] {
    OP_LHS = 3'd0,  // pass lhs
    OP_RHS = 3'd1,  // pass conditioned rhs
    OP_ADC = 3'd2,  // add with carry
    OP_AND = 3'd3,
    OP_OR  = 3'd4,
    OP_XOR = 3'd5,
    OP_ASL = 3'd6,  // shift left through carry
    OP_LSR = 3'd7   // shift right through carry
  } alu_op_e;

  // decoded control word, 13 bits
  typedef struct packed {
    // rhs conditioning
    logic    clear_rhs;
    logic    invert_rhs;
    // carry-in conditioning
    logic    clear_carry;
    logic    invert_carry_in;
    alu_op_e op;
    // flag update selects
    logic    flags_rhs;         // N,V from rhs[7:6], as for BIT
    logic    adc_overflow;      // signed add overflow into V
    logic    result_sign;       // N from result[7]
    logic    invert_carry_out;  // C gets inverted carry
    logic    set_carry;         // C gets carry
    logic    result_zero;       // Z from result
  } alu_ctrl_t;

  // processor status subset held by the unit
  typedef struct packed {
    logic carry;
    logic overflow;
    logic sign;
    logic zero;
  } alu_flags_t;

  // one command as it travels through the intake FIFO
  typedef struct packed {
    alu_ctrl_t  ctrl;
    logic       mask_p;  // low keeps flags untouched
    logic [7:0] lhs;
    logic [7:0] rhs;
  } alu_cmd_t;

  // result handed to the sink
  typedef struct packed {
    logic [7:0] value;
    alu_flags_t flags;   // flag state after the command
  } alu_res_t;

endpackage

/* design/alu_result_egress.sv */
`timescale 1ns/1ps

module alu_result_egress
  import alu_pkg::*;
#(
  parameter int RES_CREDITS = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue,
  input  alu_res_t issue_res,
  output logic     out_ready,
  output logic     res_valid,
  output alu_res_t res,
  input  logic     res_credit
);

  localparam int CNT_W = $clog2(RES_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;  // free slots at the sink

  assign out_ready = (credit_cnt != '0);

  // payload register
  always_ff @(posedge clk) begin
    if (issue) begin
      res <= issue_res;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid  <= 1'b0;
      credit_cnt <= CNT_W'(RES_CREDITS);
    end else begin
      res_valid  <= issue;  // one pulse per result
      credit_cnt <= credit_cnt + CNT_W'(res_credit) - CNT_W'(issue);
    end
  end

  // sink must not return more credits than it was given
  a_credit_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    credit_cnt <= CNT_W'(RES_CREDITS)
  ) else $error("egress credit count out of range: %0d", credit_cnt);

endmodule

/* design/alu_unit_top.sv */
`timescale 1ns/1ps

module alu_unit_top
  import alu_pkg::*;
#(
  parameter int CMD_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  alu_cmd_t cmd,
  output logic     cmd_credit,
  output logic     res_valid,
  output alu_res_t res,
  input  logic     res_credit
);

  logic     head_valid;
  alu_cmd_t head;
  logic     pop;
  logic     out_ready;
  logic     issue;
  alu_res_t issue_res;

  alu_cmd_intake #(
    .CMD_DEPTH (CMD_DEPTH)
  ) i_alu_cmd_intake (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop)
  );

  alu_exec_stage i_alu_exec_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .out_ready  (out_ready),
    .issue      (issue),
    .issue_res  (issue_res)
  );

  alu_result_egress #(
    .RES_CREDITS (RES_CREDITS)
  ) i_alu_result_egress (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_res  (issue_res),
    .out_ready  (out_ready),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

endmodule

/* design/core_alu.sv */
`timescale 1ns/1ps

module core_alu
  import alu_pkg::*;
(
  input  alu_ctrl_t  ctrl,
  input  logic       mask_p,
  input  logic [7:0] lhs,
  input  logic [7:0] rhs,
  input  alu_flags_t flags_in,
  output logic [7:0] value,
  output alu_flags_t flags_out
);

  logic [8:0] rhs_c;    // conditioned rhs, widened
  logic       carry_c;  // carry in, then carry out

  always_comb begin
    flags_out = flags_in;  // unselected flags pass through

    rhs_c = {1'b0, rhs};
    if (ctrl.clear_rhs) begin
      rhs_c = 9'd0;
    end
    if (ctrl.invert_rhs) begin
      rhs_c = ~rhs_c;
    end

    carry_c = flags_in.carry;
    if (ctrl.clear_carry) begin
      carry_c = 1'b0;
    end
    if (ctrl.invert_carry_in) begin
      carry_c = ~carry_c;
    end

    value = lhs;
    unique case (ctrl.op)
      OP_LHS: value = lhs;
      OP_RHS: value = rhs_c[7:0];
      OP_ADC: {carry_c, value} = {1'b0, lhs} + rhs_c + {8'd0, carry_c};
      OP_AND: value = lhs & rhs_c[7:0];
      OP_OR:  value = lhs | rhs_c[7:0];
      OP_XOR: value = lhs ^ rhs_c[7:0];
      OP_ASL: {carry_c, value} = {lhs, carry_c};  // bit 7 out to carry
      OP_LSR: {value, carry_c} = {carry_c, lhs};  // bit 0 out to carry
    endcase

    if (mask_p) begin
      // overflow
      if (ctrl.flags_rhs) begin
        flags_out.overflow = rhs[6];
      end else if (ctrl.adc_overflow) begin
        flags_out.overflow = (lhs[7] == rhs_c[7]) && (lhs[7] != value[7]);
      end

      // sign
      if (ctrl.flags_rhs) begin
        flags_out.sign = rhs[7];
      end else if (ctrl.result_sign) begin
        flags_out.sign = value[7];
      end

      // carry, inverted form is the borrow convention
      if (ctrl.invert_carry_out) begin
        flags_out.carry = ~carry_c;
      end else if (ctrl.set_carry) begin
        flags_out.carry = carry_c;
      end

      if (ctrl.result_zero) begin
        flags_out.zero = (value == 8'd0);
      end
    end
  end

endmodule

/* src.f */
+incdir+tests
design/alu_pkg.sv
design/core_alu.sv
design/alu_cmd_intake.sv
design/alu_exec_stage.sv
design/alu_result_egress.sv
design/alu_unit_top.sv
tests/alu_unit_tb.sv

/* tests/alu_unit_tb_ref.svh */
`ifndef ALU_UNIT_TB_REF_SVH
`define ALU_UNIT_TB_REF_SVH

// expected result of one command, given the flag state before it
function automatic alu_res_t alu_model(input alu_cmd_t c, input alu_flags_t f_in);
  logic [8:0] b;     // conditioned rhs, nine bits wide
  logic [8:0] sum;
  logic       cin;
  logic       cout;
  alu_res_t   r;
  b = c.ctrl.clear_rhs ? 9'h000 : {1'b0, c.rhs};
  if (c.ctrl.invert_rhs) begin
    b = b ^ 9'h1ff;
  end
  cin = c.ctrl.clear_carry ? 1'b0 : f_in.carry;
  cin = cin ^ c.ctrl.invert_carry_in;
  cout = cin;  // logic ops leave carry alone
  case (c.ctrl.op)
    OP_LHS: r.value = c.lhs;
    OP_RHS: r.value = b[7:0];
    OP_ADC: begin
      sum = {1'b0, c.lhs} + b + {8'h00, cin};
      r.value = sum[7:0];
      cout = sum[8];
    end
    OP_AND: r.value = c.lhs & b[7:0];
    OP_OR:  r.value = c.lhs | b[7:0];
    OP_XOR: r.value = c.lhs ^ b[7:0];
    OP_ASL: begin
      r.value = {c.lhs[6:0], cin};
      cout = c.lhs[7];
    end
    default: begin
      r.value = {cin, c.lhs[7:1]};
      cout = c.lhs[0];
    end
  endcase
  r.flags = f_in;
  if (c.mask_p) begin
    if (c.ctrl.flags_rhs) begin
      r.flags.sign = c.rhs[7];
      r.flags.overflow = c.rhs[6];
    end else begin
      if (c.ctrl.adc_overflow) begin
        r.flags.overflow = (c.lhs[7] == b[7]) && (r.value[7] != c.lhs[7]);
      end
      if (c.ctrl.result_sign) begin
        r.flags.sign = r.value[7];
      end
    end
    if (c.ctrl.invert_carry_out) begin
      r.flags.carry = !cout;
    end else if (c.ctrl.set_carry) begin
      r.flags.carry = cout;
    end
    if (c.ctrl.result_zero) begin
      r.flags.zero = (r.value == 8'h00);
    end
  end
  return r;
endfunction

task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
  if (act !== exp) begin
    fail_run($sformatf("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act));
  end
endtask

task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
  if (act !== exp) begin
    fail_run($sformatf("CHECK FAILED %s expected 0x%1h actual 0x%1h", name, exp, act));
  end
endtask

`endif

/* tests/alu_unit_tb.sv */
`timescale 1ns/1ps

module alu_unit_tb
  import alu_pkg::*;
();

  localparam int CMD_DEPTH    = 4;
  localparam int RES_CREDITS  = 2;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_DIRECTED   = 13;
  localparam int N_SWEEP      = 128;  // 8 ops x 16 conditioning combos
  localparam int N_RANDOM     = 300;
  localparam int N_CMDS       = N_DIRECTED + N_SWEEP + N_RANDOM;
  localparam int HOLD_CYCLES  = 150;
  localparam int WATCHDOG_NS  = N_CMDS * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       cmd_valid;
  alu_cmd_t   cmd;
  logic       cmd_credit;
  logic       res_valid;
  alu_res_t   res;
  logic       res_credit = 1'b0;

  integer     seed = 32'hf7cf;
  logic [31:0] sink_draw = '0;
  int         send_credits = CMD_DEPTH;
  int         sent_cnt = 0;
  int         seen_cnt = 0;
  int         credit_pulses = 0;
  int         held = 0;        // result slots taken at the sink
  int         hold_left = 0;
  logic       started = 1'b0;
  alu_flags_t model_flags = '0;
  alu_cmd_t   exp_q[$];

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  `include "alu_unit_tb_ref.svh"

  alu_unit_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) i_alu_unit_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic alu_cmd_t rand_cmd();
    logic [31:0] r;
    alu_cmd_t    c;
    r = $random(seed);
    c = r[29:0];
    r = $random(seed);
    c.mask_p = (r[1:0] != 2'b00);  // mostly flag-updating
    return c;
  endfunction

  // called on a falling edge, returns on the next one
  task automatic send_cmd(input alu_cmd_t c);
    while (send_credits == 0) begin
      @(negedge clk);
    end
    cmd_valid = 1'b1;
    cmd = c;
    exp_q.push_back(c);
    send_credits--;
    sent_cnt++;
    started = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic run_directed();
    alu_cmd_t c;
    int       i;
    c = rand_cmd();
    c.mask_p = 1'b0;  // first result carries the reset flags
    send_cmd(c);
    c = '0;  // 7f + 01 overflows into the sign bit
    c.mask_p = 1'b1;
    c.ctrl.op = OP_ADC;
    c.ctrl.clear_carry = 1'b1;
    c.ctrl.adc_overflow = 1'b1;
    c.ctrl.result_sign = 1'b1;
    c.ctrl.set_carry = 1'b1;
    c.ctrl.result_zero = 1'b1;
    c.lhs = 8'h7f;
    c.rhs = 8'h01;
    send_cmd(c);
    for (i = 0; i < 9; i++) begin
      c = rand_cmd();
      c.mask_p = (i >= 4 && i < 8);  // BIT-style in the middle, masked around it
      c.ctrl.flags_rhs = 1'b1;
      c.ctrl.adc_overflow = 1'b1;
      c.ctrl.result_sign = 1'b1;
      c.ctrl.result_zero = 1'b1;
      if (c.mask_p) begin
        c.ctrl.op = OP_AND;
        c.rhs[7:6] = 2'(i);
        if (i == 4) begin
          c.lhs = 8'h00;
        end
      end
      send_cmd(c);
    end
    c = rand_cmd();
    c.mask_p = 1'b0;
    send_cmd(c);
    send_cmd(c);
  endtask

  task automatic run_sweep();
    alu_cmd_t c;
    int       op;
    int       cond;
    for (op = 0; op < 8; op++) begin
      for (cond = 0; cond < 16; cond++) begin
        c = rand_cmd();
        c.mask_p = 1'b1;
        c.ctrl.op = alu_op_e'(op);
        {c.ctrl.clear_rhs, c.ctrl.invert_rhs, c.ctrl.clear_carry, c.ctrl.invert_carry_in} =
          4'(cond);
        send_cmd(c);
      end
    end
  endtask

  task automatic run_random(input int n);
    repeat (n) begin
      send_cmd(rand_cmd());
    end
  endtask

  always @(posedge clk) begin
    sink_draw <= $random(seed);
    if (rst_n && cmd_credit) begin
      send_credits++;
      credit_pulses++;
    end
  end

  // sink takes each result into a slot and frees slots after random delays
  always @(negedge clk) begin
    if (!rst_n) begin
      res_credit = 1'b0;
      held = 0;
    end else begin
      if (res_valid) begin
        held++;
      end
      if (held > RES_CREDITS) begin
        fail_run("more results arrived than the sink had granted credits for");
      end else if (hold_left > 0) begin
        hold_left--;
        res_credit = 1'b0;
      end else if (held > 0 && sink_draw[1:0] != 2'b00) begin
        held--;
        res_credit = 1'b1;
      end else begin
        res_credit = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && !started && (res_valid || cmd_credit)) begin
      fail_run("res_valid or cmd_credit went high before the first command");
    end
  end

  always @(negedge clk) begin
    alu_cmd_t   c;
    alu_res_t   e;
    alu_flags_t prev_flags;
    alu_flags_t bit_flags;
    if (rst_n && res_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("a result arrived with no command outstanding");
      end else begin
        c = exp_q.pop_front();
        prev_flags = model_flags;
        e = alu_model(c, prev_flags);
        model_flags = e.flags;
        check_value("res.value", e.value, res.value);
        check_flags("res.flags", e.flags, res.flags);
        if (c.mask_p && c.ctrl.flags_rhs) begin
          bit_flags = res.flags;
          bit_flags.sign = c.rhs[7];
          bit_flags.overflow = c.rhs[6];
          check_flags("res.flags (BIT N/V)", bit_flags, res.flags);
        end
        seen_cnt++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    if (send_credits == 0 && exp_q.size() == 0) begin
      fail_run("sender stalled with no command credit left, a cmd_credit pulse went missing");
    end else begin
      fail_run($sformatf("run did not finish in time, %0d of %0d results seen",
                         seen_cnt, sent_cnt));
    end
  end

  initial begin
    cmd_valid = 1'b0;
    cmd = '0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (5) @(negedge clk);  // idle outputs must stay low
    run_directed();
    run_sweep();
    run_random(N_RANDOM / 2);
    hold_left = HOLD_CYCLES;    // long credit drought at the sink
    run_random(N_RANDOM - N_RANDOM / 2);
    while (seen_cnt < sent_cnt || credit_pulses < sent_cnt) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (credit_pulses == sent_cnt && seen_cnt == sent_cnt && exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run($sformatf("extra activity after drain, %0d results and %0d credits for %0d cmds",
                         seen_cnt, credit_pulses, sent_cnt));
    end
  end

endmodule
